/* Makefile */
# Verilator simulation of the NTS engine statistics block

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_nts_engine -Mdir obj_dir -o tb_nts_engine
	./obj_dir/tb_nts_engine +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* list.f */
nts_engine_pkg.sv
nts_event_counter.sv
nts_debug_regs.sv
nts_api_decode.sv
nts_engine_top.sv
tb_nts_engine_assert.sv
tb_nts_engine.sv

/* nts_api_decode.sv */
// API decoder of the NTS engine
// Splits the 12-bit address into block and internal address, serves the
// engine identity words and registers the read response one cycle later

`timescale 1ns/1ps

module nts_api_decode
  import nts_engine_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_areset,
  input  logic      i_api_cs,
  input  api_req_t  i_api_req,
  output logic      o_debug_rd_en,
  output api_addr_t o_debug_addr,
  input  api_word_t i_debug_rd_data,
  output api_rsp_t  o_api_rsp
);

  logic [3:0] blk;
  api_addr_t  addr;
  logic       api_rd;
  api_word_t  engine_word;
  api_word_t  rd_word;
  logic       rsp_valid_reg;
  api_word_t  rsp_data_reg;

  //--------------------------------------------------------------------------
  // Address split and block select
  //--------------------------------------------------------------------------

  assign blk    = i_api_req.addr[11:8];
  assign addr   = i_api_req.addr[7:0];
  assign api_rd = i_api_cs & ~i_api_req.we;  // Writes are dropped here

  assign o_debug_rd_en = api_rd && (blk == BLK_DEBUG);
  assign o_debug_addr  = addr;

  // Engine identity block
  always_comb
  begin
    case (addr)
      ADDR_NAME0:   engine_word = CORE_NAME0;
      ADDR_NAME1:   engine_word = CORE_NAME1;
      ADDR_VERSION: engine_word = CORE_VERSION;
      ADDR_CTRL:    engine_word = CTRL_VALUE;
      default:      engine_word = '0;
    endcase
  end

  // Clock, cookie, keymem and parser blocks are not present and read zero
  always_comb
  begin
    case (blk)
      BLK_ENGINE: rd_word = engine_word;
      BLK_DEBUG:  rd_word = i_debug_rd_data;
      default:    rd_word = '0;
    endcase
  end

  //--------------------------------------------------------------------------
  // Registered response
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      rsp_valid_reg <= 1'b0;
    else
      rsp_valid_reg <= api_rd;  // One cycle per read, no back-pressure
  end

  always_ff @(posedge i_clk)
  begin
    if (api_rd)
      rsp_data_reg <= rd_word;
  end

  assign o_api_rsp.valid = rsp_valid_reg;
  assign o_api_rsp.data  = rsp_data_reg;

endmodule

/* nts_debug_regs.sv */
// Debug register block of the NTS engine
// Six event counters with coherent upper/lower reads, a free-running
// system tick and the debug name word, read through the internal address

`timescale 1ns/1ps

module nts_debug_regs
  import nts_engine_pkg::*;
#(
  parameter int CNT_WIDTH = 64
)
(
  input  logic         i_clk,
  input  logic         i_areset,
  input  stat_events_t i_events,
  input  logic         i_rd_en,    // Debug block read this cycle
  input  api_addr_t    i_addr,
  output api_word_t    o_rd_data
);

  localparam int NUM_CNT = 6;

  // Base address of each counter, same order as the inc vector
  localparam api_addr_t CNT_BASE [NUM_CNT] = '{
    ADDR_DEBUG_NTS_PROCESSED,
    ADDR_DEBUG_NTS_BAD_COOKIE,
    ADDR_DEBUG_NTS_BAD_AUTH,
    ADDR_DEBUG_NTS_BAD_KEYID,
    ADDR_DEBUG_ERROR_CRYPTO,
    ADDR_DEBUG_ERROR_TXBUF
  };

  logic [NUM_CNT-1:0] cnt_inc;
  logic [NUM_CNT-1:0] cnt_snap;
  api_word_t          cnt_upper [NUM_CNT];
  api_word_t          cnt_lower [NUM_CNT];
  api_word_t          systick_reg;
  api_word_t          rd_data;

  //--------------------------------------------------------------------------
  // Event counters
  //--------------------------------------------------------------------------

  assign cnt_inc[0] = i_events.nts_processed;
  assign cnt_inc[1] = i_events.nts_bad_cookie;
  assign cnt_inc[2] = i_events.nts_bad_auth;
  assign cnt_inc[3] = i_events.nts_bad_keyid;
  assign cnt_inc[4] = i_events.error_crypto;
  assign cnt_inc[5] = i_events.error_txbuf;

  for (genvar g = 0; g < NUM_CNT; g++)
  begin : g_cnt
    nts_event_counter #(
      .CNT_WIDTH (CNT_WIDTH)
    ) u_cnt (
      .i_clk        (i_clk),
      .i_areset     (i_areset),
      .i_inc        (cnt_inc[g]),
      .i_snapshot   (cnt_snap[g]),
      .o_upper      (cnt_upper[g]),
      .o_lower_snap (cnt_lower[g])
    );
  end

  //--------------------------------------------------------------------------
  // System tick
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= SYSTICK_RESET;  // Reads 1 as reset drops
    else
      systick_reg <= systick_reg + 32'd1;
  end

  //--------------------------------------------------------------------------
  // Read mux and snapshot strobes
  //--------------------------------------------------------------------------

  always_comb
  begin
    rd_data  = '0;  // Unmapped addresses
    cnt_snap = '0;

    case (i_addr)
      ADDR_DEBUG_NAME:      rd_data = DEBUG_NAME;
      ADDR_DEBUG_SYSTICK32: rd_data = systick_reg;
      default: ;
    endcase

    // Counter pairs, no overlap with the fixed words above
    for (int k = 0; k < NUM_CNT; k++)
    begin
      if (i_addr == CNT_BASE[k])
      begin
        rd_data     = cnt_upper[k];
        cnt_snap[k] = i_rd_en;  // Capture lower word on real reads only
      end
      else if (i_addr == (CNT_BASE[k] + 8'd1))
      begin
        rd_data = cnt_lower[k];
      end
    end
  end

  assign o_rd_data = rd_data;

endmodule

/* nts_engine_pkg.sv */
// NTS engine shared definitions
// API request and response structs, event strobes, address map and the
// identity words of the engine and debug blocks

package nts_engine_pkg;

  //--------------------------------------------------------------------------
  // Basic API types
  //--------------------------------------------------------------------------

  typedef logic [31:0] api_word_t;  // API data word
  typedef logic [7:0]  api_addr_t;  // Address inside one block

  // One request on the external API, qualified by chip select
  typedef struct packed {
    logic        we;     // Write flag
    logic [11:0] addr;   // Block select in 11:8, internal address in 7:0
    api_word_t   wdata;
  } api_req_t;

  // Registered read response
  typedef struct packed {
    logic      valid;
    api_word_t data;
  } api_rsp_t;

  // Single-cycle event strobes from parser, crypto and TX buffer
  typedef struct packed {
    logic nts_processed;
    logic nts_bad_cookie;
    logic nts_bad_auth;
    logic nts_bad_keyid;
    logic error_crypto;
    logic error_txbuf;
  } stat_events_t;

  //--------------------------------------------------------------------------
  // Block selectors, address bits 11:8
  //--------------------------------------------------------------------------

  localparam logic [3:0] BLK_ENGINE = 4'd0;
  localparam logic [3:0] BLK_DEBUG  = 4'd1;

  // Engine block
  localparam api_addr_t ADDR_NAME0   = 8'h00;
  localparam api_addr_t ADDR_NAME1   = 8'h01;
  localparam api_addr_t ADDR_VERSION = 8'h02;
  localparam api_addr_t ADDR_CTRL    = 8'h08;

  localparam api_word_t CORE_NAME0   = 32'h4e_54_53_5f;  // "NTS_"
  localparam api_word_t CORE_NAME1   = 32'h45_4e_47_4e;  // "ENGN"
  localparam api_word_t CORE_VERSION = 32'h30_2e_30_32;  // "0.02"
  localparam api_word_t CTRL_VALUE   = 32'h0000_0001;

  // Debug block, counter base reads upper word and base+1 the lower word
  localparam api_addr_t ADDR_DEBUG_NTS_PROCESSED  = 8'h00;
  localparam api_addr_t ADDR_DEBUG_NTS_BAD_COOKIE = 8'h02;
  localparam api_addr_t ADDR_DEBUG_NTS_BAD_AUTH   = 8'h04;
  localparam api_addr_t ADDR_DEBUG_NTS_BAD_KEYID  = 8'h06;
  localparam api_addr_t ADDR_DEBUG_NAME           = 8'h08;
  localparam api_addr_t ADDR_DEBUG_SYSTICK32      = 8'h09;
  localparam api_addr_t ADDR_DEBUG_ERROR_CRYPTO   = 8'h20;
  localparam api_addr_t ADDR_DEBUG_ERROR_TXBUF    = 8'h22;

  localparam api_word_t DEBUG_NAME    = 32'h44_42_55_47;  // "DBUG"
  localparam api_word_t SYSTICK_RESET = 32'h0000_0001;

endpackage

/* nts_engine_top.sv */
// NTS engine statistics and register top level
// Joins the API decoder with the debug counter block

`timescale 1ns/1ps

module nts_engine_top
  import nts_engine_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_areset,
  input  logic         i_api_cs,
  input  api_req_t     i_api_req,
  input  stat_events_t i_events,
  output api_rsp_t     o_api_rsp
);

  localparam int CNT_WIDTH = 64;  // Event counter width

  logic      debug_rd_en;
  api_addr_t debug_addr;
  api_word_t debug_rd_data;

  //--------------------------------------------------------------------------
  // API decode
  //--------------------------------------------------------------------------

  nts_api_decode u_api_decode (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_api_cs        (i_api_cs),
    .i_api_req       (i_api_req),
    .o_debug_rd_en   (debug_rd_en),
    .o_debug_addr    (debug_addr),
    .i_debug_rd_data (debug_rd_data),
    .o_api_rsp       (o_api_rsp)
  );

  //--------------------------------------------------------------------------
  // Debug counters and tick
  //--------------------------------------------------------------------------

  nts_debug_regs #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_debug_regs (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_events  (i_events),
    .i_rd_en   (debug_rd_en),
    .i_addr    (debug_addr),
    .o_rd_data (debug_rd_data)
  );

endmodule

/* nts_event_counter.sv */
// Event counter for the debug block
// Wide counter bumped by a strobe, plus a register that captures the
// lower word when the upper word is read

`timescale 1ns/1ps

module nts_event_counter
  import nts_engine_pkg::*;
#(
  parameter int CNT_WIDTH = 64
)
(
  input  logic      i_clk,
  input  logic      i_areset,
  input  logic      i_inc,         // Event strobe
  input  logic      i_snapshot,    // Upper word being read
  output api_word_t o_upper,
  output api_word_t o_lower_snap
);

  logic [CNT_WIDTH-1:0] cnt_reg;
  api_word_t            snap_reg;

  // Counter and snapshot share the edge, so the snapshot sees the
  // pre-increment value
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cnt_reg  <= '0;
      snap_reg <= '0;
    end
    else
    begin
      if (i_inc)
        cnt_reg <= cnt_reg + 1'b1;
      if (i_snapshot)
        snap_reg <= cnt_reg[31:0];  // Lower word before increment
    end
  end

  // Upper part zero-extended for widths below 64
  assign o_upper      = api_word_t'(cnt_reg[CNT_WIDTH-1:32]);
  assign o_lower_snap = snap_reg;

endmodule

/* tb_nts_engine.sv */
// Testbench for the NTS engine statistics and register top level
// Random events and API traffic against a cycle model

`timescale 1ns/1ps

module tb_nts_engine
  import nts_engine_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int RST_CYCLES  = 10;
  localparam int RAND_CYCLES = 2000;
  localparam int WR_COUNT    = 300;
  localparam int B2B_COUNT   = 300;
  localparam int TEST_CYCLES = RST_CYCLES + RAND_CYCLES + WR_COUNT + B2B_COUNT + 400;
  localparam int DRAIN_LIMIT = 20;

  // Counter upper-word addresses in event struct order
  localparam logic [7:0] CNT_ADDR [6] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  logic         i_clk;
  logic         i_areset;
  logic         i_api_cs;
  api_req_t     i_api_req;
  stat_events_t i_events;
  api_rsp_t     o_api_rsp;

  logic [63:0]  m_cnt [6];     // Model counters
  logic [31:0]  m_snap [6];    // Model lower-word snapshots
  logic [31:0]  m_tick;
  logic [31:0]  exp_q [$];     // Expected read words in issue order
  logic [11:0]  addr_q [$];
  logic [31:0]  rsp_log [$];   // Every response word seen
  logic [31:0]  seed = 32'd1;
  int           checks = 0;
  int           errors = 0;

  nts_engine_top u_dut (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_api_cs  (i_api_cs),
    .i_api_req (i_api_req),
    .i_events  (i_events),
    .o_api_rsp (o_api_rsp)
  );

  initial
    i_clk = 1'b0;

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic stat_events_t rand_events();
    logic [31:0] r;
    r = lcg_next();
    return stat_events_t'(r[31:26] & r[25:20]);  // About one in four per event
  endfunction

  // Expected read word from the address map and the model state
  function automatic logic [31:0] model_read(input logic [11:0] a);
    logic [31:0] w;
    w = 32'h0;
    if (a[11:8] == 4'h0)
    begin
      case (a[7:0])
        8'h00: w = 32'h4e54535f;  // "NTS_"
        8'h01: w = 32'h454e474e;  // "ENGN"
        8'h02: w = 32'h302e3032;  // "0.02"
        8'h08: w = 32'h00000001;
        default: w = 32'h0;
      endcase
    end
    else if (a[11:8] == 4'h1)
    begin
      if (a[7:0] == 8'h08)
        w = 32'h44425547;  // "DBUG"
      else if (a[7:0] == 8'h09)
        w = m_tick;
      for (int k = 0; k < 6; k++)
      begin
        if (a[7:0] == CNT_ADDR[k])
          w = m_cnt[k][63:32];
        else if (a[7:0] == CNT_ADDR[k] + 8'h01)
          w = m_snap[k];
      end
    end
    return w;
  endfunction

  //--------------------------------------------------------------------------
  // Reference model and response checker
  //--------------------------------------------------------------------------

  always @(posedge i_clk)
  begin
    logic [31:0] exp_word;
    logic [11:0] exp_addr;
    logic [5:0]  ev;
    ev = i_events;
    if (i_areset)
    begin
      for (int k = 0; k < 6; k++)
      begin
        m_cnt[k]  = 64'h0;
        m_snap[k] = 32'h0;
      end
      m_tick = 32'd1;  // Tick reads 1 on the first edge out of reset
    end
    else
    begin
      if (o_api_rsp.valid)
      begin
        rsp_log.push_back(o_api_rsp.data);
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("Response valid with no read outstanding, data %h", o_api_rsp.data);
        end
        else
        begin
          exp_word = exp_q.pop_front();
          exp_addr = addr_q.pop_front();
          checks++;
          if (o_api_rsp.data !== exp_word)
          begin
            errors++;
            $display("Mismatch o_api_rsp.data at addr %h: got %h, expected %h",
                     exp_addr, o_api_rsp.data, exp_word);
          end
        end
      end
      if (i_api_cs && !i_api_req.we)
      begin
        exp_q.push_back(model_read(i_api_req.addr));
        addr_q.push_back(i_api_req.addr);
        for (int k = 0; k < 6; k++)
          if (i_api_req.addr == {4'h1, CNT_ADDR[k]})
            m_snap[k] = m_cnt[k][31:0];  // Pre-increment lower word
      end
      for (int k = 0; k < 6; k++)
        if (ev[5-k])
          m_cnt[k] = m_cnt[k] + 64'd1;
      m_tick = m_tick + 32'd1;
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus tasks
  //--------------------------------------------------------------------------

  task automatic drive(input logic cs, input logic we, input logic [11:0] addr,
                       input logic [31:0] wdata, input stat_events_t ev);
    @(posedge i_clk);
    i_api_cs        <= cs;
    i_api_req.we    <= we;
    i_api_req.addr  <= addr;
    i_api_req.wdata <= wdata;
    i_events        <= ev;
  endtask

  task automatic read_req(input logic [11:0] addr, input stat_events_t ev);
    drive(1'b1, 1'b0, addr, 32'h0, ev);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, 12'h0, 32'h0, '0);
  endtask

  // Wait until every issued read has returned or the drain limit runs out
  task automatic wait_drain();
    int n;
    idle(1);
    n = 0;
    do
    begin
      @(negedge i_clk);
      n++;
    end
    while (exp_q.size() != 0 && n < DRAIN_LIMIT);
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("Read responses missing, %0d still outstanding", exp_q.size());
      exp_q.delete();
      addr_q.delete();
    end
  endtask

  task automatic read_counters();
    for (int k = 0; k < 6; k++)
    begin
      read_req({4'h1, CNT_ADDR[k]}, '0);
      read_req({4'h1, CNT_ADDR[k] + 8'h01}, '0);  // Lower word after upper
    end
    wait_drain();
  endtask

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------

  initial
  begin
    logic [31:0] r;
    int          k_gap;
    int          afails;
    i_areset  = 1'b1;
    i_api_cs  = 1'b0;
    i_api_req = '0;
    i_events  = '0;
    repeat (RST_CYCLES) @(posedge i_clk);
    i_areset <= 1'b0;

    // Engine identity block and the absent blocks
    for (int a = 0; a < 16; a++)
      read_req(12'(a), '0);
    for (int b = 2; b < 16; b++)
      read_req({4'(b), 8'h00}, '0);
    wait_drain();

    // Random events followed by a read of every counter
    for (int i = 0; i < RAND_CYCLES; i++)
      drive(1'b0, 1'b0, 12'h0, 32'h0, rand_events());
    read_counters();

    // Upper read in the same cycle as that counter's event
    for (int k = 0; k < 6; k++)
    begin
      read_req({4'h1, CNT_ADDR[k]}, stat_events_t'(6'b100000 >> k));
      read_req({4'h1, CNT_ADDR[k] + 8'h01}, '0);
    end
    wait_drain();
    read_counters();

    // Writes to random addresses and to every counter word
    for (int i = 0; i < WR_COUNT; i++)
    begin
      r = lcg_next();
      drive(1'b1, 1'b1, r[27:16], lcg_next(), rand_events());
    end
    for (int k = 0; k < 6; k++)
    begin
      drive(1'b1, 1'b1, {4'h1, CNT_ADDR[k]}, lcg_next(), rand_events());
      drive(1'b1, 1'b1, {4'h1, CNT_ADDR[k] + 8'h01}, lcg_next(), rand_events());
    end
    wait_drain();
    for (int a = 0; a < 16; a++)
      read_req(12'(a), '0);
    // Snapshots still hold what the last upper reads captured
    for (int k = 0; k < 6; k++)
      read_req({4'h1, CNT_ADDR[k] + 8'h01}, '0);
    read_counters();

    // System tick distance and debug name
    k_gap = 3 + int'(lcg_next() >> 27);
    rsp_log.delete();
    read_req(12'h109, '0);
    idle(k_gap - 1);
    read_req(12'h109, '0);
    read_req(12'h108, '0);
    wait_drain();
    if (rsp_log.size() != 3)
    begin
      errors++;
      $display("Tick test returned %0d responses instead of 3", rsp_log.size());
    end
    else if (rsp_log[1] - rsp_log[0] != 32'(k_gap))
    begin
      errors++;
      $display("Mismatch systick delta: got %h, expected %h",
               rsp_log[1] - rsp_log[0], 32'(k_gap));
    end

    // Reads on every cycle
    rsp_log.delete();
    for (int i = 0; i < B2B_COUNT; i++)
    begin
      r = lcg_next();
      read_req({2'b00, r[31:30], 2'b00, r[29], 1'b0, r[28:25]}, rand_events());
    end
    wait_drain();
    if (rsp_log.size() != B2B_COUNT)
    begin
      errors++;
      $display("Back-to-back reads gave %0d responses, expected %0d",
               rsp_log.size(), B2B_COUNT);
    end

    afails = u_dut.u_api_decode.u_assert.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
    if (errors == 0 && afails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout, the test sequence did not complete");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tb_nts_engine_assert.sv */
// API handshake assertions for the NTS engine decoder
// Response valid against read and write strobes, and during reset

`timescale 1ns/1ps

module tb_nts_engine_assert
  import nts_engine_pkg::*;
(
  input logic     i_clk,
  input logic     i_areset,
  input logic     i_api_cs,
  input api_req_t i_api_req,
  input api_rsp_t i_api_rsp
);

  int   fail_cnt = 0;  // Read by the testbench at the end
  logic api_rd;
  logic api_wr;

  assign api_rd = i_api_cs & ~i_api_req.we;
  assign api_wr = i_api_cs & i_api_req.we;

  a_rd_rsp: assert property (@(posedge i_clk) disable iff (i_areset)
    api_rd |=> i_api_rsp.valid)
  else
  begin
    fail_cnt++;
    $error("Read strobe not followed by valid one cycle later");
  end

  a_rsp_src: assert property (@(posedge i_clk) disable iff (i_areset)
    i_api_rsp.valid |-> $past(api_rd))
  else
  begin
    fail_cnt++;
    $error("Valid without a read strobe in the cycle before");
  end

  a_no_wr_rsp: assert property (@(posedge i_clk) disable iff (i_areset)
    api_wr |=> !i_api_rsp.valid)
  else
  begin
    fail_cnt++;
    $error("Valid raised after a write");
  end

  a_rst: assert property (@(posedge i_clk) i_areset |-> !i_api_rsp.valid)
  else
  begin
    fail_cnt++;
    $error("Valid high during reset");
  end

endmodule

bind nts_api_decode tb_nts_engine_assert u_assert (
  .i_clk     (i_clk),
  .i_areset  (i_areset),
  .i_api_cs  (i_api_cs),
  .i_api_req (i_api_req),
  .i_api_rsp (o_api_rsp)
);
